// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_la32_int_core
RTL_TOP    := la32_int_core
FLIST      := flist.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation FAILED
PASS_MSG   := Simulation PASSED
SOURCES    := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== core_if.sv ====
`timescale 1ns/1ps

interface dec_exe_if import core_pkg::*; ();
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       inst;
    alu_op_e               op;
    src_b_e                src_b;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rk;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rj_val;
    logic [XLEN-1:0]       rk_val;
    logic                  writes_rd;

    modport dec (output valid, pc, inst, op, src_b, rd, rj, rk, imm, rj_val, rk_val,
                 writes_rd);
    modport exe (input valid, pc, inst, op, src_b, rd, rj, rk, imm, rj_val, rk_val,
                 writes_rd);
endinterface

interface exe_res_if import core_pkg::*; ();
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       inst;
    logic [REG_ADDR_W-1:0] rd;
    logic                  writes_rd;
    logic [XLEN-1:0]       result;

    // writeback register, looped back for forwarding
    logic                  wb_valid;
    logic                  wb_wen;
    logic [REG_ADDR_W-1:0] wb_wnum;
    logic [XLEN-1:0]       wb_wdata;

    modport exe (output valid, pc, inst, rd, writes_rd, result,
                 input  wb_valid, wb_wen, wb_wnum, wb_wdata);
    modport res (input  valid, pc, inst, rd, writes_rd, result,
                 output wb_valid, wb_wen, wb_wnum, wb_wdata);
endinterface

// ==== core_pkg.sv ====
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // instruction field positions
    localparam int FLD_RD_LO     = 0;
    localparam int FLD_RJ_LO     = 5;
    localparam int FLD_RK_LO     = 10;
    localparam int FLD_SI12_LO   = 10;
    localparam int FLD_SI20_LO   = 5;
    localparam int SI12_W        = 12;
    localparam int SI20_W        = 20;
    localparam int OPC_3R_LO     = 15;
    localparam int OPC_2RI12_LO  = 22;
    localparam int OPC_LU12I_LO  = 25;

    // 3R group, bits 31:15
    localparam logic [16:0] OPC_3R_ADD  = 17'h00020;
    localparam logic [16:0] OPC_3R_SUB  = 17'h00022;
    localparam logic [16:0] OPC_3R_SLT  = 17'h00024;
    localparam logic [16:0] OPC_3R_SLTU = 17'h00025;
    localparam logic [16:0] OPC_3R_AND  = 17'h00029;
    localparam logic [16:0] OPC_3R_OR   = 17'h0002a;
    localparam logic [16:0] OPC_3R_XOR  = 17'h0002b;
    localparam logic [16:0] OPC_3R_SLL  = 17'h0002e;
    localparam logic [16:0] OPC_3R_SRL  = 17'h0002f;
    localparam logic [16:0] OPC_3R_SRA  = 17'h00030;

    // 2RI12 group, bits 31:22
    localparam logic [9:0] OPC_2RI12_ADDI = 10'h00a;
    localparam logic [9:0] OPC_2RI12_ANDI = 10'h00d;
    localparam logic [9:0] OPC_2RI12_ORI  = 10'h00e;
    localparam logic [9:0] OPC_2RI12_XORI = 10'h00f;

    localparam logic [6:0] OPC_LU12I = 7'h0a;

    typedef enum logic [3:0] {
        OP_NONE, OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND,
        OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA, OP_LUI
    } alu_op_e;

    typedef enum logic {
        SRC_B_REG,
        SRC_B_IMM
    } src_b_e;

endpackage

// ==== core_testdata.hex ====
// pc       inst     wen wnum wdata
// pc 0x1xxx sent with random idle gaps, pc 0x2xxx sent back to back
00001000 15000001 1 01 80000000 // lu12i.w r1, 0x80000
00001004 02bffc02 1 02 ffffffff // addi.w r2, r0, -1
00001008 02801403 1 03 00000005 // addi.w r3, r0, 5
0000100c 00100c44 1 04 00000004 // add.w r4, r2, r3
00001010 00110865 1 05 00000006 // sub.w r5, r3, r2
00001014 00120c26 1 06 00000001 // slt r6, r1, r3
00001018 00128c27 1 07 00000000 // sltu r7, r1, r3
0000101c 00128869 1 09 00000001 // sltu r9, r3, r2
00001020 0014844a 1 0a 80000000 // and r10, r2, r1
00001024 00150c2b 1 0b 80000005 // or r11, r1, r3
00001028 00158c4c 1 0c fffffffa // xor r12, r2, r3
0000102c 00178c2e 1 0e 04000000 // srl.w r14, r1, r3
00001030 02808c10 1 10 00000023 // addi.w r16, r0, 35
00001034 00174071 1 11 00000028 // sll.w r17, r3, r16
00001038 00184032 1 12 f0000000 // sra.w r18, r1, r16
0000103c 0363c054 1 14 000008f0 // andi r20, r2, 0x8f0
00001040 03bffc35 1 15 80000fff // ori r21, r1, 0xfff
00001044 03e00056 1 16 fffff7ff // xori r22, r2, 0x800
00001048 02bfe077 1 17 fffffffd // addi.w r23, r3, -8
0000104c 142468b8 1 18 12345000 // lu12i.w r24, 0x12345
00001050 02801c60 0 00 00000000 // addi.w r0, r3, 7
00001054 00100c19 1 19 00000005 // add.w r25, r0, r3
00001058 ffffffff 0 00 00000000 // undefined
0000105c 02848c1a 1 1a 00000123 // addi.w r26, r0, 0x123
00001060 00106b5b 1 1b 00000246 // add.w r27, r26, r26
00001064 00116b7c 1 1c 00000123 // sub.w r28, r27, r26
00001068 0015ef9d 1 1d 00000365 // xor r29, r28, r27
00002000 02848c1a 1 1a 00000123 // addi.w r26, r0, 0x123
00002004 00106b5b 1 1b 00000246 // add.w r27, r26, r26
00002008 00116b7c 1 1c 00000123 // sub.w r28, r27, r26
0000200c 0015ef9d 1 1d 00000365 // xor r29, r28, r27
00002010 001077a0 0 00 00000000 // add.w r0, r29, r29
00002014 0015741f 1 1f 00000365 // or r31, r0, r29

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_inst_valid,
    input  logic [XLEN-1:0]       i_inst_pc,
    input  logic [XLEN-1:0]       i_inst,
    output logic [REG_ADDR_W-1:0] o_rj_addr,
    output logic [REG_ADDR_W-1:0] o_rk_addr,
    input  logic [XLEN-1:0]       i_rj_val,
    input  logic [XLEN-1:0]       i_rk_val,
    dec_exe_if.dec                de
);
    logic              valid_q;
    logic [XLEN-1:0]   pc_q;
    logic [XLEN-1:0]   inst_q;
    logic [SI12_W-1:0] si12;
    logic [SI20_W-1:0] si20;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_inst_valid) begin
            pc_q   <= i_inst_pc;
            inst_q <= i_inst;
        end
    end

    assign si12 = inst_q[FLD_SI12_LO +: SI12_W];
    assign si20 = inst_q[FLD_SI20_LO +: SI20_W];

    always_comb begin
        de.op        = OP_NONE;
        de.src_b     = SRC_B_REG;
        de.imm       = '0;
        case (inst_q[XLEN-1:OPC_3R_LO])
            OPC_3R_ADD:  de.op = OP_ADD;
            OPC_3R_SUB:  de.op = OP_SUB;
            OPC_3R_SLT:  de.op = OP_SLT;
            OPC_3R_SLTU: de.op = OP_SLTU;
            OPC_3R_AND:  de.op = OP_AND;
            OPC_3R_OR:   de.op = OP_OR;
            OPC_3R_XOR:  de.op = OP_XOR;
            OPC_3R_SLL:  de.op = OP_SLL;
            OPC_3R_SRL:  de.op = OP_SRL;
            OPC_3R_SRA:  de.op = OP_SRA;
            default: begin
                de.src_b = SRC_B_IMM;
                // logic immediates are zero extended
                de.imm   = {{(XLEN-SI12_W){1'b0}}, si12};
                case (inst_q[XLEN-1:OPC_2RI12_LO])
                    OPC_2RI12_ADDI: begin
                        de.op  = OP_ADD;
                        de.imm = {{(XLEN-SI12_W){si12[SI12_W-1]}}, si12};
                    end
                    OPC_2RI12_ANDI: de.op = OP_AND;
                    OPC_2RI12_ORI:  de.op = OP_OR;
                    OPC_2RI12_XORI: de.op = OP_XOR;
                    default: begin
                        if (inst_q[XLEN-1:OPC_LU12I_LO] == OPC_LU12I) begin
                            de.op  = OP_LUI;
                            de.imm = {si20, {(XLEN-SI20_W){1'b0}}};
                        end
                    end
                endcase
            end
        endcase
        // undefined encodings retire as no-ops
        de.writes_rd = (de.op != OP_NONE);
    end

    assign o_rj_addr = inst_q[FLD_RJ_LO +: REG_ADDR_W];
    assign o_rk_addr = inst_q[FLD_RK_LO +: REG_ADDR_W];

    assign de.valid  = valid_q;
    assign de.pc     = pc_q;
    assign de.inst   = inst_q;
    assign de.rd     = inst_q[FLD_RD_LO +: REG_ADDR_W];
    assign de.rj     = o_rj_addr;
    assign de.rk     = o_rk_addr;
    assign de.rj_val = i_rj_val;
    assign de.rk_val = i_rk_val;

    a_inst_known: assert property (@(posedge clk) disable iff (!rstn)
        valid_q |-> !$isunknown(inst_q));

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    dec_exe_if.exe de,
    exe_res_if.exe er
);
    logic                  valid_q;
    logic [XLEN-1:0]       pc_q;
    logic [XLEN-1:0]       inst_q;
    alu_op_e               op_q;
    src_b_e                src_b_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [REG_ADDR_W-1:0] rj_q;
    logic [REG_ADDR_W-1:0] rk_q;
    logic [XLEN-1:0]       imm_q;
    logic [XLEN-1:0]       rj_val_q;
    logic [XLEN-1:0]       rk_val_q;
    logic                  writes_rd_q;
    logic                  wb_hit;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       rk_fwd;
    logic [XLEN-1:0]       op_b;
    logic [4:0]            shamt;
    logic [XLEN-1:0]       alu_res;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= de.valid;
        end
    end

    always_ff @(posedge clk) begin
        pc_q        <= de.pc;
        inst_q      <= de.inst;
        op_q        <= de.op;
        src_b_q     <= de.src_b;
        rd_q        <= de.rd;
        rj_q        <= de.rj;
        rk_q        <= de.rk;
        imm_q       <= de.imm;
        rj_val_q    <= de.rj_val;
        rk_val_q    <= de.rk_val;
        writes_rd_q <= de.writes_rd && de.valid;
    end

    // distance 1 dependency comes from the writeback register
    assign wb_hit = er.wb_valid && er.wb_wen && er.wb_wnum != '0;
    assign op_a   = (wb_hit && er.wb_wnum == rj_q) ? er.wb_wdata : rj_val_q;
    assign rk_fwd = (wb_hit && er.wb_wnum == rk_q) ? er.wb_wdata : rk_val_q;
    assign op_b   = (src_b_q == SRC_B_IMM) ? imm_q : rk_fwd;
    assign shamt  = op_b[4:0];

    always_comb begin
        case (op_q)
            OP_ADD:  alu_res = op_a + op_b;
            OP_SUB:  alu_res = op_a - op_b;
            OP_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            OP_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            OP_AND:  alu_res = op_a & op_b;
            OP_OR:   alu_res = op_a | op_b;
            OP_XOR:  alu_res = op_a ^ op_b;
            OP_SLL:  alu_res = op_a << shamt;
            OP_SRL:  alu_res = op_a >> shamt;
            OP_SRA:  alu_res = $signed(op_a) >>> shamt;
            OP_LUI:  alu_res = imm_q;
            default: alu_res = '0;
        endcase
    end

    assign er.valid     = valid_q;
    assign er.pc        = pc_q;
    assign er.inst      = inst_q;
    assign er.rd        = rd_q;
    assign er.writes_rd = writes_rd_q;
    assign er.result    = alu_res;

endmodule

// ==== flist.f ====
core_pkg.sv
core_if.sv
register_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
la32_int_core.sv
tb_clock_gen.sv
tb_la32_int_core.sv

// ==== la32_int_core.sv ====
`timescale 1ns/1ps

module la32_int_core import core_pkg::*; #(
    parameter int CNT_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_inst_valid,
    input  logic [XLEN-1:0]       i_inst_pc,
    input  logic [XLEN-1:0]       i_inst,
    output logic                  o_wb_valid,
    output logic [XLEN-1:0]       o_wb_pc,
    output logic [XLEN-1:0]       o_wb_inst,
    output logic                  o_wb_wen,
    output logic [REG_ADDR_W-1:0] o_wb_wnum,
    output logic [XLEN-1:0]       o_wb_wdata,
    output logic [CNT_WIDTH-1:0]  o_retired
);
    logic [REG_ADDR_W-1:0] rj_addr;
    logic [REG_ADDR_W-1:0] rk_addr;
    logic [XLEN-1:0]       rj_val;
    logic [XLEN-1:0]       rk_val;

    dec_exe_if de_if ();
    exe_res_if er_if ();

    decode_stage u_decode (
        .clk          (clk),
        .rstn         (rstn),
        .i_inst_valid (i_inst_valid),
        .i_inst_pc    (i_inst_pc),
        .i_inst       (i_inst),
        .o_rj_addr    (rj_addr),
        .o_rk_addr    (rk_addr),
        .i_rj_val     (rj_val),
        .i_rk_val     (rk_val),
        .de           (de_if.dec)
    );

    // write port fed straight from the writeback register
    register_file u_regfile (
        .clk       (clk),
        .rstn      (rstn),
        .i_rj_addr (rj_addr),
        .i_rk_addr (rk_addr),
        .o_rj_val  (rj_val),
        .o_rk_val  (rk_val),
        .i_we      (er_if.wb_wen),
        .i_waddr   (er_if.wb_wnum),
        .i_wdata   (er_if.wb_wdata)
    );

    execute_stage u_execute (
        .clk  (clk),
        .rstn (rstn),
        .de   (de_if.exe),
        .er   (er_if.exe)
    );

    result_stage #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_result (
        .clk        (clk),
        .rstn       (rstn),
        .er         (er_if.res),
        .o_wb_valid (o_wb_valid),
        .o_wb_pc    (o_wb_pc),
        .o_wb_inst  (o_wb_inst),
        .o_wb_wen   (o_wb_wen),
        .o_wb_wnum  (o_wb_wnum),
        .o_wb_wdata (o_wb_wdata),
        .o_retired  (o_retired)
    );

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [REG_ADDR_W-1:0] i_rj_addr,
    input  logic [REG_ADDR_W-1:0] i_rk_addr,
    output logic [XLEN-1:0]       o_rj_val,
    output logic [XLEN-1:0]       o_rk_val,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_waddr,
    input  logic [XLEN-1:0]       i_wdata
);
    // r0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (i_we && i_waddr == addr) begin
            // same-edge write seen by the reader
            return i_wdata;
        end else begin
            return regs[addr];
        end
    endfunction

    always_ff @(posedge clk) begin
        if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    always_comb begin
        o_rj_val = read_port(i_rj_addr);
        o_rk_val = read_port(i_rk_addr);
    end

    // result stage must never request a write to r0
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rstn) i_we |-> i_waddr != '0);

endmodule

// ==== result_stage.sv ====
`timescale 1ns/1ps

module result_stage import core_pkg::*; #(
    parameter int CNT_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rstn,
    exe_res_if.res                er,
    output logic                  o_wb_valid,
    output logic [XLEN-1:0]       o_wb_pc,
    output logic [XLEN-1:0]       o_wb_inst,
    output logic                  o_wb_wen,
    output logic [REG_ADDR_W-1:0] o_wb_wnum,
    output logic [XLEN-1:0]       o_wb_wdata,
    output logic [CNT_WIDTH-1:0]  o_retired
);
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_wb_valid <= 1'b0;
            o_wb_wen   <= 1'b0;
            o_retired  <= '0;
        end else begin
            o_wb_valid <= er.valid;
            // writes to r0 are dropped here
            o_wb_wen   <= er.writes_rd && er.rd != '0;
            if (er.valid) begin
                o_retired <= o_retired + CNT_WIDTH'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        o_wb_pc    <= er.pc;
        o_wb_inst  <= er.inst;
        o_wb_wnum  <= er.rd;
        o_wb_wdata <= er.result;
    end

    assign er.wb_valid = o_wb_valid;
    assign er.wb_wen   = o_wb_wen;
    assign er.wb_wnum  = o_wb_wnum;
    assign er.wb_wdata = o_wb_wdata;

    a_wen_valid: assert property (@(posedge clk) disable iff (!rstn) o_wb_wen |-> o_wb_valid);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rstn
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

    // released on the rising edge that ends the reset window
    initial begin
        o_rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rstn <= 1'b1;
    end
endmodule

// ==== tb_la32_int_core.sv ====
`timescale 1ns/1ps

module tb_la32_int_core import core_pkg::*; ();
    localparam int CNT_WIDTH   = 16;
    localparam int NUM_RECS    = 33;
    localparam int REC_WORDS   = 5;
    localparam int RESET_LIMIT = 20;
    localparam int DRAIN_LIMIT = 60;

    logic                  clk;
    logic                  rstn;
    logic                  i_inst_valid;
    logic [XLEN-1:0]       i_inst_pc;
    logic [XLEN-1:0]       i_inst;
    logic                  o_wb_valid;
    logic [XLEN-1:0]       o_wb_pc;
    logic [XLEN-1:0]       o_wb_inst;
    logic                  o_wb_wen;
    logic [REG_ADDR_W-1:0] o_wb_wnum;
    logic [XLEN-1:0]       o_wb_wdata;
    logic [CNT_WIDTH-1:0]  o_retired;

    // record k: pc, inst, wen, wnum, wdata at words 5k .. 5k+4
    logic [31:0] test_words [0:NUM_RECS*REC_WORDS-1];

    int unsigned seed_value;
    int          errors      = 0;
    int          checks      = 0;
    int          edge_cnt    = 0;
    int          trace_count = 0;
    int          capture_edges [$];
    int          rec_base;
    int          capture_edge;

    tb_clock_gen clock_gen_i (
        .o_clk  (clk),
        .o_rstn (rstn)
    );

    la32_int_core #(
        .CNT_WIDTH (CNT_WIDTH)
    ) dut_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_inst_valid (i_inst_valid),
        .i_inst_pc    (i_inst_pc),
        .i_inst       (i_inst),
        .o_wb_valid   (o_wb_valid),
        .o_wb_pc      (o_wb_pc),
        .o_wb_inst    (o_wb_inst),
        .o_wb_wen     (o_wb_wen),
        .o_wb_wnum    (o_wb_wnum),
        .o_wb_wdata   (o_wb_wdata),
        .o_retired    (o_retired)
    );

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    // pcs 0x1xxx get random idle gaps, pcs 0x2xxx go back to back
    function automatic logic gapped_region(input logic [31:0] pc);
        return pc[15:12] == 4'h1;
    endfunction

    // trace compared on the falling edge, between DUT updates
    always @(negedge clk) begin
        if (rstn && o_wb_valid) begin
            if (trace_count >= NUM_RECS || capture_edges.size() == 0) begin
                errors++;
                $display("ERROR: time=%0t trace record with no matching input", $time);
            end else begin
                rec_base     = trace_count * REC_WORDS;
                capture_edge = capture_edges.pop_front();
                check_value("o_wb_pc", test_words[rec_base], o_wb_pc);
                check_value("o_wb_inst", test_words[rec_base + 1], o_wb_inst);
                check_value("o_wb_wen", test_words[rec_base + 2], 32'(o_wb_wen));
                if (test_words[rec_base + 2][0]) begin
                    check_value("o_wb_wnum", test_words[rec_base + 3], 32'(o_wb_wnum));
                    check_value("o_wb_wdata", test_words[rec_base + 4], o_wb_wdata);
                end
                // captured at edge E, trace register loaded at E+2
                check_value("o_wb_valid edge", capture_edge + 2, edge_cnt);
                trace_count++;
            end
        end
        if (rstn && i_inst_valid) begin
            capture_edges.push_back(edge_cnt + 1);
        end
    end

    task automatic check_reset_state();
        int waited;
        waited = 0;
        // last pass covers the first cycle after release
        do begin
            @(negedge clk);
            check_value("o_wb_valid", 32'd0, 32'(o_wb_valid));
            check_value("o_wb_wen", 32'd0, 32'(o_wb_wen));
            check_value("o_retired", 32'd0, 32'(o_retired));
            waited++;
        end while (!rstn && waited < RESET_LIMIT);
        if (!rstn) begin
            errors++;
            $display("ERROR: reset was never released");
        end
    endtask

    task automatic send_records();
        int k;
        int gap;
        for (k = 0; k < NUM_RECS; k++) begin
            gap = 0;
            if (gapped_region(test_words[k * REC_WORDS])) begin
                gap = $urandom_range(2, 0);
            end
            repeat (gap) begin
                @(posedge clk);
                i_inst_valid <= 1'b0;
            end
            @(posedge clk);
            i_inst_valid <= 1'b1;
            i_inst_pc    <= test_words[k * REC_WORDS];
            i_inst       <= test_words[k * REC_WORDS + 1];
        end
        @(posedge clk);
        i_inst_valid <= 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (trace_count < NUM_RECS && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (trace_count < NUM_RECS) begin
            errors++;
            $display("ERROR: timed out with %0d of %0d trace records seen",
                     trace_count, NUM_RECS);
        end
        // idle tail to catch stray trace records
        repeat (4) @(negedge clk);
    endtask

    initial begin
        i_inst_valid = 1'b0;
        i_inst_pc    = '0;
        i_inst       = '0;
        seed_value   = $urandom(99016);
        $readmemh("core_testdata.hex", test_words);
        if ($isunknown(test_words[NUM_RECS*REC_WORDS-1])) begin
            errors++;
            $display("ERROR: data file holds fewer records than expected");
        end
        check_reset_state();
        send_records();
        wait_for_drain();
        check_value("o_retired", NUM_RECS, 32'(o_retired));
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
